// File: source/switch_pkg.sv
package switch_pkg;

	// ------------------------------------------------------------------------
	// Switch geometry
	// ------------------------------------------------------------------------

	// Number of input and output ports
	parameter int num_ports = 4;

	// Full packet width, header in the low byte and payload in the high byte
	parameter int packet_width = 16;

	// ------------------------------------------------------------------------
	// Field types
	// ------------------------------------------------------------------------

	// One packet as stored in a FIFO and driven on an output
	typedef logic [packet_width-1:0] packet_t;

	// Set of ports, one bit per port
	// Used for source and target masks, requests and grants
	typedef logic [num_ports-1:0] port_mask_t;

	// Index of a single port, for the pointer and the output selects
	typedef logic [$clog2(num_ports)-1:0] port_sel_t;

	// ------------------------------------------------------------------------
	// Port state machine
	// ------------------------------------------------------------------------

	// idle      waiting for a packet in the FIFO
	// route     header at the FIFO head is checked
	// arb_wait  requesting the target outputs until granted
	// transmit  one cycle after the grant while the packet leaves
	typedef enum logic [1:0] {
		idle,
		route,
		arb_wait,
		transmit
	} port_state_t;

endpackage

// File: source/packet_fifo.sv
module packet_fifo import switch_pkg::*; #(
	parameter int depth = 8
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    wr_en,
	input  packet_t wr_data,
	input  logic    rd_en,
	output packet_t head,
	output logic    empty,
	output logic    full
);

	localparam int ptr_width = $clog2(depth);

	// Pointers wrap on their own since depth is a power of two
	typedef logic [ptr_width-1:0] fifo_ptr_t;
	typedef logic [ptr_width:0] fifo_count_t;

	packet_t     mem [depth];
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_count_t count;
	logic        wr_ok;
	logic        rd_ok;

	// Writes while full and reads while empty are ignored
	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;

	assign empty = (count == '0);
	assign full  = (count == fifo_count_t'(depth));

	// Head is visible before it is read so the port can check the header
	assign head = mem[rd_ptr];

	// ------------------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ------------------------------------------------------------------------
	// Pointers and occupancy
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + fifo_ptr_t'(1);
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + fifo_ptr_t'(1);
			end
			// Simultaneous read and write leaves the count unchanged
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + fifo_count_t'(1);
				2'b01:   count <= count - fifo_count_t'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

// File: source/switch_port.sv
module switch_port import switch_pkg::*; #(
	parameter int depth = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_en,
	input  packet_t    wr_data,
	output logic       full,
	output port_mask_t req,
	input  logic       grant,
	output packet_t    head
);

	port_state_t state;
	port_state_t next_state;
	logic        fifo_empty;
	logic        rd_en;
	port_mask_t  src_mask;
	port_mask_t  tgt_mask;
	logic        valid_header;

	// ------------------------------------------------------------------------
	// Input FIFO
	// ------------------------------------------------------------------------

	packet_fifo #(
		.depth(depth)
	) u_packet_fifo (
		.clk    (clk),
		.rst    (rst),
		.wr_en  (wr_en),
		.wr_data(wr_data),
		.rd_en  (rd_en),
		.head   (head),
		.empty  (fifo_empty),
		.full   (full)
	);

	// ------------------------------------------------------------------------
	// Header check
	// ------------------------------------------------------------------------

	// Source in the low nibble, target in the next one
	assign src_mask = head[num_ports-1:0];
	assign tgt_mask = head[2*num_ports-1:num_ports];

	// A packet must go somewhere and never back to where it came from
	assign valid_header = (tgt_mask != '0) && ((tgt_mask & src_mask) == '0);

	// Request is a level for as long as we wait for the grant
	assign req = (state == arb_wait) ? tgt_mask : '0;

	// Pop on a grant, or discard a bad packet straight from route
	assign rd_en = ((state == arb_wait) && grant) ||
		((state == route) && !valid_header);

	// ------------------------------------------------------------------------
	// Routing FSM
	// ------------------------------------------------------------------------

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (!fifo_empty) begin
					next_state = route;
				end
			end
			route: begin
				if (valid_header) begin
					next_state = arb_wait;
				end else begin
					next_state = idle;
				end
			end
			arb_wait: begin
				if (grant) begin
					next_state = transmit;
				end
			end
			transmit: begin
				next_state = idle;
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

endmodule

// File: source/crossbar_arbiter.sv
module crossbar_arbiter import switch_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  port_mask_t req0,
	input  port_mask_t req1,
	input  port_mask_t req2,
	input  port_mask_t req3,
	input  packet_t    head0,
	input  packet_t    head1,
	input  packet_t    head2,
	input  packet_t    head3,
	output port_mask_t grant,
	output port_mask_t out_valid,
	output packet_t    out_data0,
	output packet_t    out_data1,
	output packet_t    out_data2,
	output packet_t    out_data3
);

	port_sel_t  ptr;
	port_mask_t reqs [num_ports];
	packet_t    heads [num_ports];
	port_sel_t  win_sel [num_ports];
	port_mask_t win_valid;
	port_mask_t won [num_ports];
	port_mask_t next_active;
	packet_t    out_data_q [num_ports];

	// Gather the per-port buses so the selection can loop over them
	assign reqs[0]  = req0;
	assign reqs[1]  = req1;
	assign reqs[2]  = req2;
	assign reqs[3]  = req3;
	assign heads[0] = head0;
	assign heads[1] = head1;
	assign heads[2] = head2;
	assign heads[3] = head3;

	// ------------------------------------------------------------------------
	// Round-robin pointer, shared by all outputs
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr <= '0;
		end else begin
			ptr <= ptr + port_sel_t'(1);
		end
	end

	// ------------------------------------------------------------------------
	// Winner per output, first requester at or after the pointer
	// ------------------------------------------------------------------------

	always_comb begin : winner_search
		port_sel_t idx;
		for (int o = 0; o < num_ports; o++) begin
			win_sel[o]   = '0;
			win_valid[o] = 1'b0;
			for (int k = 0; k < num_ports; k++) begin
				idx = ptr + port_sel_t'(k);
				if (!win_valid[o] && reqs[idx][o]) begin
					win_sel[o]   = idx;
					win_valid[o] = 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// All-or-nothing grants
	// ------------------------------------------------------------------------

	// won[p] holds the outputs that port p won this cycle
	always_comb begin
		for (int p = 0; p < num_ports; p++) begin
			for (int o = 0; o < num_ports; o++) begin
				won[p][o] = win_valid[o] && (win_sel[o] == port_sel_t'(p));
			end
			// A multicast port only goes when every copy can leave together
			grant[p] = (reqs[p] != '0) && ((reqs[p] & ~won[p]) == '0);
		end
	end

	// An output fires only if its winner was granted as a whole
	always_comb begin
		for (int o = 0; o < num_ports; o++) begin
			next_active[o] = win_valid[o] && grant[win_sel[o]];
		end
	end

	// ------------------------------------------------------------------------
	// Registered output multiplexers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= '0;
		end else begin
			out_valid <= next_active;
		end
	end

	// Head is captured in the grant cycle, before the FIFO moves on
	always_ff @(posedge clk) begin
		for (int o = 0; o < num_ports; o++) begin
			if (next_active[o]) begin
				out_data_q[o] <= heads[win_sel[o]];
			end
		end
	end

	assign out_data0 = out_data_q[0];
	assign out_data1 = out_data_q[1];
	assign out_data2 = out_data_q[2];
	assign out_data3 = out_data_q[3];

endmodule

// File: source/packet_switch.sv
module packet_switch import switch_pkg::*; #(
	parameter int depth = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  port_mask_t in_valid,
	input  packet_t    in_data0,
	input  packet_t    in_data1,
	input  packet_t    in_data2,
	input  packet_t    in_data3,
	output port_mask_t in_full,
	output port_mask_t out_valid,
	output packet_t    out_data0,
	output packet_t    out_data1,
	output packet_t    out_data2,
	output packet_t    out_data3
);

	port_mask_t req0;
	port_mask_t req1;
	port_mask_t req2;
	port_mask_t req3;
	packet_t    head0;
	packet_t    head1;
	packet_t    head2;
	packet_t    head3;
	port_mask_t grant;

	// ------------------------------------------------------------------------
	// Input ports
	// ------------------------------------------------------------------------

	switch_port #(.depth(depth)) u_port0 (
		.clk(clk), .rst(rst),
		.wr_en(in_valid[0]), .wr_data(in_data0), .full(in_full[0]),
		.req(req0), .grant(grant[0]), .head(head0)
	);

	switch_port #(.depth(depth)) u_port1 (
		.clk(clk), .rst(rst),
		.wr_en(in_valid[1]), .wr_data(in_data1), .full(in_full[1]),
		.req(req1), .grant(grant[1]), .head(head1)
	);

	switch_port #(.depth(depth)) u_port2 (
		.clk(clk), .rst(rst),
		.wr_en(in_valid[2]), .wr_data(in_data2), .full(in_full[2]),
		.req(req2), .grant(grant[2]), .head(head2)
	);

	switch_port #(.depth(depth)) u_port3 (
		.clk(clk), .rst(rst),
		.wr_en(in_valid[3]), .wr_data(in_data3), .full(in_full[3]),
		.req(req3), .grant(grant[3]), .head(head3)
	);

	// ------------------------------------------------------------------------
	// Crossbar
	// ------------------------------------------------------------------------

	crossbar_arbiter u_crossbar_arbiter (
		.clk      (clk),
		.rst      (rst),
		.req0     (req0),
		.req1     (req1),
		.req2     (req2),
		.req3     (req3),
		.head0    (head0),
		.head1    (head1),
		.head2    (head2),
		.head3    (head3),
		.grant    (grant),
		.out_valid(out_valid),
		.out_data0(out_data0),
		.out_data1(out_data1),
		.out_data2(out_data2),
		.out_data3(out_data3)
	);

endmodule

// File: tb/switch_assertions.sv
module switch_assertions import switch_pkg::*; #(
	parameter int depth = 8
) (
	input logic                   clk,
	input logic                   rst,
	input port_state_t            state,
	input logic                   grant,
	input logic                   rd_en,
	input logic                   fifo_empty,
	input logic [$clog2(depth):0] count,
	input logic [$clog2(depth)-1:0] wr_ptr,
	input logic [$clog2(depth)-1:0] rd_ptr
);

	timeunit 1ns;
	timeprecision 100ps;

	// Failed properties, polled by the testbench
	int unsigned fail_count = 0;

	// ------------------------------------------------------------------------
	// FIFO properties
	// ------------------------------------------------------------------------

	no_read_while_empty: assert property (@(posedge clk) disable iff (rst)
		rd_en |-> !fifo_empty)
		else begin
			fail_count++;
			$error("FIFO read while empty");
		end

	// A zero count means the pointers have met with nothing stored
	empty_at_zero_count: assert property (@(posedge clk) disable iff (rst)
		(count == '0) |-> (wr_ptr == rd_ptr))
		else begin
			fail_count++;
			$error("FIFO count is zero but the pointers differ");
		end

	// ------------------------------------------------------------------------
	// Port FSM properties
	// ------------------------------------------------------------------------

	wait_holds_without_grant: assert property (@(posedge clk) disable iff (rst)
		(state == arb_wait && !grant) |=> (state == arb_wait))
		else begin
			fail_count++;
			$error("Port left arb_wait without a grant");
		end

	grant_to_transmit: assert property (@(posedge clk) disable iff (rst)
		(state == arb_wait && grant) |=> (state == transmit))
		else begin
			fail_count++;
			$error("Granted port did not move to transmit");
		end

	// A pop is either a drop out of route or a grant out of arb_wait
	read_on_grant_or_drop: assert property (@(posedge clk) disable iff (rst)
		rd_en |=> (($past(state) == route && state == idle) ||
			($past(state) == arb_wait && state == transmit)))
		else begin
			fail_count++;
			$error("FIFO read outside grant or drop");
		end

	busy_needs_packet: assert property (@(posedge clk) disable iff (rst)
		(state == route || state == arb_wait) |-> !fifo_empty)
		else begin
			fail_count++;
			$error("Port busy with an empty FIFO");
		end

endmodule

bind switch_port switch_assertions #(.depth(depth)) u_switch_assertions (
	.clk       (clk),
	.rst       (rst),
	.state     (state),
	.grant     (grant),
	.rd_en     (rd_en),
	.fifo_empty(fifo_empty),
	.count     (u_packet_fifo.count),
	.wr_ptr    (u_packet_fifo.wr_ptr),
	.rd_ptr    (u_packet_fifo.rd_ptr)
);

// File: tb/tb_packet_switch.sv
module tb_packet_switch import switch_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int depth = 8;
	localparam int drain_limit = 2000;

	logic       clk;
	logic       rst;
	port_mask_t in_valid;
	packet_t    in_data [num_ports];
	port_mask_t in_full;
	port_mask_t out_valid;
	packet_t    out_data [num_ports];

	// Expected packets, one queue per input and output pair
	packet_t    exp_q [num_ports*num_ports][$];
	port_mask_t full_seen;
	port_mask_t ever_full;
	port_mask_t wrote_last;
	int         sent_valid;
	int         sent_dropped;
	int         multicast_sent;
	int         delivered;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	packet_switch #(.depth(depth)) u_packet_switch (
		.clk(clk), .rst(rst),
		.in_valid(in_valid),
		.in_data0(in_data[0]), .in_data1(in_data[1]),
		.in_data2(in_data[2]), .in_data3(in_data[3]),
		.in_full(in_full),
		.out_valid(out_valid),
		.out_data0(out_data[0]), .out_data1(out_data[1]),
		.out_data2(out_data[2]), .out_data3(out_data[3])
	);

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------

	task automatic fail_and_stop();
		$display("tests failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_packet(string test_name, packet_t expected, packet_t actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %h actual %h", test_name, expected, actual);
			fail_and_stop();
		end
	endtask

	task automatic check_mask(string test_name, port_mask_t expected, port_mask_t actual);
		if (expected !== actual) begin
			$display("ERROR %s expected %b actual %b", test_name, expected, actual);
			fail_and_stop();
		end
	endtask

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------

	// Index of a one-hot source field, -1 if it is not one-hot
	function automatic int source_index(packet_t pkt);
		int idx;
		idx = -1;
		for (int p = 0; p < num_ports; p++) begin
			if (pkt[num_ports-1:0] == port_mask_t'(1 << p)) begin
				idx = p;
			end
		end
		return idx;
	endfunction

	// Valid when the target is non-empty and excludes the source
	function automatic logic header_valid(packet_t pkt);
		port_mask_t src;
		port_mask_t tgt;
		src = pkt[num_ports-1:0];
		tgt = pkt[2*num_ports-1:num_ports];
		return (tgt != '0) && ((tgt & src) == '0);
	endfunction

	function automatic int pending_packets();
		int total;
		total = 0;
		for (int i = 0; i < num_ports*num_ports; i++) begin
			total += exp_q[i].size();
		end
		return total;
	endfunction

	// Mostly valid traffic, one in ten with an empty target, one in ten looping back
	function automatic packet_t make_packet(int port);
		port_mask_t src;
		port_mask_t tgt;
		logic [7:0] payload;
		int         kind;
		src = port_mask_t'(1 << port);
		payload = 8'($urandom);
		kind = int'($urandom_range(9, 0));
		tgt = port_mask_t'($urandom);
		if (kind == 0) begin
			tgt = '0;
		end else if (kind == 1) begin
			tgt = tgt | src;
		end else begin
			tgt = tgt & ~src;
			if (tgt == '0) begin
				tgt = port_mask_t'(1 << ((port + 1) % num_ports));
			end
		end
		return {payload, tgt, src};
	endfunction

	task automatic record_write(int port, packet_t pkt);
		port_mask_t tgt;
		tgt = pkt[2*num_ports-1:num_ports];
		if (header_valid(pkt)) begin
			sent_valid++;
			if ($countones(tgt) > 1) begin
				multicast_sent++;
			end
			for (int o = 0; o < num_ports; o++) begin
				if (tgt[o]) begin
					exp_q[port*num_ports+o].push_back(pkt);
				end
			end
		end else begin
			sent_dropped++;
		end
	endtask

	// A port rests after each write, so full sampled at the falling edge is never stale
	task automatic drive_inputs(int write_pct);
		port_mask_t valid_next;
		packet_t    pkt;
		valid_next = '0;
		for (int p = 0; p < num_ports; p++) begin
			if (!wrote_last[p] && !full_seen[p] && ($urandom_range(99, 0) < write_pct)) begin
				pkt = make_packet(p);
				in_data[p] <= pkt;
				valid_next[p] = 1'b1;
				record_write(p, pkt);
			end
		end
		in_valid <= valid_next;
		wrote_last = valid_next;
	endtask

	task automatic run_traffic(int cycles, int write_pct);
		repeat (cycles) begin
			@(posedge clk);
			drive_inputs(write_pct);
		end
	endtask

	// Each output must match its pair queue, copies of one packet leave together
	task automatic check_outputs();
		port_mask_t src_outputs [num_ports];
		packet_t    expected;
		int         src;
		for (int s = 0; s < num_ports; s++) begin
			src_outputs[s] = '0;
		end
		for (int o = 0; o < num_ports; o++) begin
			if (out_valid[o]) begin
				src = source_index(out_data[o]);
				if (src < 0 || exp_q[src*num_ports+o].size() == 0) begin
					$display("Output %0d carried packet %h that was not expected",
						o, out_data[o]);
					fail_and_stop();
				end
				expected = exp_q[src*num_ports+o].pop_front();
				check_packet($sformatf("delivery port %0d to output %0d", src, o),
					expected, out_data[o]);
				src_outputs[src][o] = 1'b1;
				delivered++;
			end
		end
		for (int o = 0; o < num_ports; o++) begin
			if (out_valid[o]) begin
				src = source_index(out_data[o]);
				check_mask($sformatf("multicast from port %0d", src),
					out_data[o][2*num_ports-1:num_ports], src_outputs[src]);
			end
		end
	endtask

	// Outputs are registered, so the falling edge sees each cycle once
	always @(negedge clk) begin
		if (!rst) begin
			full_seen = in_full;
			ever_full = ever_full | in_full;
			if (u_packet_switch.u_port0.u_switch_assertions.fail_count != 0 ||
				u_packet_switch.u_port1.u_switch_assertions.fail_count != 0 ||
				u_packet_switch.u_port2.u_switch_assertions.fail_count != 0 ||
				u_packet_switch.u_port3.u_switch_assertions.fail_count != 0) begin
				$display("A port assertion failed");
				fail_and_stop();
			end
			check_outputs();
		end
	end

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------

	initial begin
		int wait_cycles;
		void'($urandom(32'h2b57));
		rst = 1'b1;
		in_valid = '0;
		for (int p = 0; p < num_ports; p++) begin
			in_data[p] = '0;
		end
		full_seen = '0;
		ever_full = '0;
		wrote_last = '0;
		sent_valid = 0;
		sent_dropped = 0;
		multicast_sent = 0;
		delivered = 0;

		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_mask("reset out_valid", '0, out_valid);
		check_mask("reset in_full", '0, in_full);

		// Light traffic first, then a heavy burst to force back-pressure
		run_traffic(1000, 30);
		run_traffic(2000, 90);
		@(posedge clk);
		in_valid <= '0;
		wrote_last = '0;

		wait_cycles = 0;
		while (pending_packets() != 0 && wait_cycles < drain_limit) begin
			@(posedge clk);
			wait_cycles++;
		end
		// Quiet period to catch stray outputs
		repeat (20) @(posedge clk);
		check_mask("drain in_full", '0, full_seen);

		$display("sent %0d valid (%0d multicast), dropped %0d, delivered %0d copies",
			sent_valid, multicast_sent, sent_dropped, delivered);
		if (pending_packets() != 0) begin
			$display("Drain timed out with %0d packets still expected", pending_packets());
			fail_and_stop();
		end else if (ever_full == '0) begin
			$display("in_full never rose under heavy traffic");
			fail_and_stop();
		end else if (sent_dropped == 0 || multicast_sent == 0) begin
			$display("Traffic mix had no drops or no multicast packets");
			fail_and_stop();
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// File: files.f
source/switch_pkg.sv
source/packet_fifo.sv
source/switch_port.sv
source/crossbar_arbiter.sv
source/packet_switch.sv
tb/switch_assertions.sv
tb/tb_packet_switch.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_packet_switch
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
